// ==== compile.f ====
tau_pkg.sv
src_broadcast.sv
grid_offset_stepper.sv
worker_issue_slot.sv
parallel_block_looper.sv
tb_parallel_block_looper.sv

// ==== grid_offset_stepper.sv ====
// Takes one job and walks its block grid from zero in raster order over a rdy/ack output
`timescale 1ns/1ps

module grid_offset_stepper #(
	parameter int WORK_BW = tau_pkg::WORK_BW_DEF,
	parameter int VDIM    = tau_pkg::VDIM_DEF
) (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_job_rdy,
	output logic               o_job_ack,
	input  logic [WORK_BW-1:0] i_step [VDIM],
	input  logic [WORK_BW-1:0] i_end  [VDIM],
	output logic               o_ofs_rdy,
	input  logic               i_ofs_ack,
	output logic [WORK_BW-1:0] o_ofs  [VDIM]
);

	// ========================================
	// Internal
	// ========================================
	tau_pkg::stepper_state_e state_r;
	logic [WORK_BW-1:0] step_r  [VDIM];
	logic [WORK_BW-1:0] end_r   [VDIM];
	logic [WORK_BW-1:0] coord_r [VDIM];
	logic [WORK_BW-1:0] coord_w [VDIM];
	logic grid_empty;
	logic is_last;
	logic ofs_xfer;

	// ========================================
	// Combinational
	// ========================================

	// Any zero end means no blocks at all
	always_comb begin
		grid_empty = 1'b0;
		for (int d = 0; d < VDIM; d++) begin
			if (i_end[d] == '0) grid_empty = 1'b1;
		end
	end

	// Odometer, fastest dimension is VDIM-1
	// One extra bit on the sum so the compare never wraps
	always_comb begin
		logic carry;
		logic [WORK_BW:0] sum;
		carry = 1'b1;
		for (int d = VDIM-1; d >= 0; d--) begin
			sum = {1'b0, coord_r[d]} + {1'b0, step_r[d]};
			coord_w[d] = coord_r[d];
			if (carry) begin
				if (sum >= {1'b0, end_r[d]}) begin
					// Wrap and carry into the next slower dimension
					coord_w[d] = '0;
				end else begin
					coord_w[d] = sum[WORK_BW-1:0];
					carry = 1'b0;
				end
			end
		end
		// Carry out of dimension 0 means the grid is done
		is_last = carry;
	end

	assign o_ofs_rdy = (state_r == tau_pkg::ST_RUN);
	assign ofs_xfer  = o_ofs_rdy && i_ofs_ack;
	assign o_ofs     = coord_r;

	// Job ack with the final offset, or straight away on an empty grid
	always_comb begin
		if (state_r == tau_pkg::ST_IDLE) begin
			o_job_ack = i_job_rdy && grid_empty;
		end else begin
			o_job_ack = i_job_rdy && ofs_xfer && is_last;
		end
	end

	// ========================================
	// Sequential
	// ========================================
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state_r <= tau_pkg::ST_IDLE;
			for (int d = 0; d < VDIM; d++) begin
				coord_r[d] <= '0;
			end
		end else begin
			case (state_r)
				tau_pkg::ST_IDLE: begin
					if (i_job_rdy && !grid_empty) begin
						state_r <= tau_pkg::ST_RUN;
						for (int d = 0; d < VDIM; d++) begin
							coord_r[d] <= '0;
						end
					end
				end
				tau_pkg::ST_RUN: begin
					if (ofs_xfer) begin
						// On the last block every coordinate wraps back to zero
						coord_r <= coord_w;
						if (is_last) state_r <= tau_pkg::ST_IDLE;
					end
				end
				default: state_r <= tau_pkg::ST_IDLE;
			endcase
		end
	end

	// Job fields sampled while idle
	always_ff @(posedge i_clk) begin
		if (state_r == tau_pkg::ST_IDLE && i_job_rdy) begin
			step_r <= i_step;
			end_r  <= i_end;
		end
	end

endmodule

// ==== parallel_block_looper.sv ====
// Top level: spreads the block offsets of one job over N_TAU worker lanes and acks when all are done
`timescale 1ns/1ps

module parallel_block_looper #(
	parameter int WORK_BW     = tau_pkg::WORK_BW_DEF,
	parameter int VDIM        = tau_pkg::VDIM_DEF,
	parameter int N_TAU       = tau_pkg::N_TAU_DEF,
	parameter int MAX_PENDING = tau_pkg::MAX_PENDING_DEF
) (
	input  logic               i_clk,
	input  logic               i_rst_n,
	// Job source
	input  logic               i_src_rdy,
	output logic               o_src_ack,
	input  logic [WORK_BW-1:0] i_bgrid_step [VDIM],
	input  logic [WORK_BW-1:0] i_bgrid_end  [VDIM],
	// Worker lanes
	output logic [N_TAU-1:0]   o_bofs_rdys,
	input  logic [N_TAU-1:0]   i_bofs_acks,
	output logic [WORK_BW-1:0] o_bofss [N_TAU][VDIM],
	input  logic [N_TAU-1:0]   i_blkdone_dvals
);

	// ========================================
	// Parameter
	// ========================================
	localparam int PTR_BW = (N_TAU > 1) ? $clog2(N_TAU) : 1;

	// ========================================
	// Internal
	// ========================================
	// Broadcast branches, 0 is the stepper, 1 the waiter
	logic [1:0] brd_rdys;
	logic [1:0] brd_acks;
	logic       job_ack;
	logic       wait_ack;
	// Stepper output
	logic               step_rdy;
	logic               step_ack;
	logic [WORK_BW-1:0] step_ofs [VDIM];
	// Lane selection
	logic [PTR_BW-1:0] ptr_r;
	logic [N_TAU-1:0]  lane_free;
	logic [N_TAU-1:0]  lane_sel;
	logic [N_TAU-1:0]  lane_take;
	logic [N_TAU-1:0]  lane_idle;

	// ========================================
	// Round-robin selection
	// ========================================
	// First free lane from the pointer upward, wrapping around
	always_comb begin
		int   idx;
		logic found;
		lane_sel = '0;
		found    = 1'b0;
		for (int k = 0; k < N_TAU; k++) begin
			idx = int'(ptr_r) + k;
			if (idx >= N_TAU) idx = idx - N_TAU;
			if (!found && lane_free[idx]) begin
				lane_sel[idx] = 1'b1;
				found = 1'b1;
			end
		end
	end

	// A take is the step transfer itself, so the step ack is their OR
	assign lane_take = lane_sel & {N_TAU{step_rdy}};
	assign step_ack  = |lane_take;

	// Pointer moves on every handoff, no matter which lane won
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			ptr_r <= '0;
		end else if (step_ack) begin
			ptr_r <= (ptr_r == PTR_BW'(N_TAU - 1)) ? '0 : ptr_r + 1'b1;
		end
	end

	// ========================================
	// Completion
	// ========================================
	// Waiter is offered only after the stepper branch is done,
	// then waits for every lane to drain
	assign wait_ack = brd_rdys[1] && (&lane_idle) && !(|o_bofs_rdys);
	assign brd_acks = {wait_ack, job_ack};

	// ========================================
	// Submodules
	// ========================================
	src_broadcast u_brd (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_src_rdy  (i_src_rdy),
		.o_src_ack  (o_src_ack),
		.o_dst_rdys (brd_rdys),
		.i_dst_acks (brd_acks)
	);

	grid_offset_stepper #(
		.WORK_BW (WORK_BW),
		.VDIM    (VDIM)
	) u_stepper (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_job_rdy (brd_rdys[0]),
		.o_job_ack (job_ack),
		.i_step    (i_bgrid_step),
		.i_end     (i_bgrid_end),
		.o_ofs_rdy (step_rdy),
		.i_ofs_ack (step_ack),
		.o_ofs     (step_ofs)
	);

	// One issue slot per lane
	for (genvar g = 0; g < N_TAU; g++) begin : g_lane
		worker_issue_slot #(
			.WORK_BW     (WORK_BW),
			.VDIM        (VDIM),
			.MAX_PENDING (MAX_PENDING)
		) u_slot (
			.i_clk      (i_clk),
			.i_rst_n    (i_rst_n),
			.i_take     (lane_take[g]),
			.o_free     (lane_free[g]),
			.i_ofs      (step_ofs),
			.o_bofs_rdy (o_bofs_rdys[g]),
			.i_bofs_ack (i_bofs_acks[g]),
			.o_bofs     (o_bofss[g]),
			.i_blkdone  (i_blkdone_dvals[g]),
			.o_idle     (lane_idle[g])
		);
	end

endmodule

// ==== src_broadcast.sv ====
// Forks one rdy/ack job to the stepper and the completion waiter, in that order
`timescale 1ns/1ps

module src_broadcast (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_src_rdy,
	output logic       o_src_ack,
	output logic [1:0] o_dst_rdys,
	input  logic [1:0] i_dst_acks
);

	// One flag per branch, set once that branch has acked
	logic [1:0] done_r;
	logic [1:0] done_or_ack;

	// Branch 0 is the stepper and is offered first
	// Branch 1 (waiter) only after the stepper has finished,
	// so completion cannot be seen before any block went out
	assign o_dst_rdys[0] = i_src_rdy && !done_r[0];
	assign o_dst_rdys[1] = i_src_rdy && done_r[0] && !done_r[1];

	assign done_or_ack = done_r | (i_dst_acks & o_dst_rdys);

	// Source ack in the cycle where the last branch acks
	assign o_src_ack = i_src_rdy && (&done_or_ack);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			done_r <= '0;
		end else if (o_src_ack) begin
			// Job finished, ready for the next one
			done_r <= '0;
		end else begin
			done_r <= done_or_ack;
		end
	end

endmodule

// ==== tau_pkg.sv ====
// Shared sizes and state encodings for the block looper, referenced by scoped name
package tau_pkg;

	// ========================================
	// Default sizes
	// ========================================

	// Bits per offset coordinate
	localparam int WORK_BW_DEF = 16;

	// Grid dimensions, last one runs fastest
	localparam int VDIM_DEF = 2;

	// Worker lanes fed round-robin
	localparam int N_TAU_DEF = 4;

	// Blocks a lane may have out before it stalls
	localparam int MAX_PENDING_DEF = 3;

	// ========================================
	// State encodings
	// ========================================

	// Grid stepper
	// ST_IDLE waits for a job, ST_RUN offers offsets
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_RUN  = 2'd1
	} stepper_state_e;

	// Lane forward register
	// SLOT_HELD means an offset waits for the worker
	typedef enum logic {
		SLOT_EMPTY = 1'b0,
		SLOT_HELD  = 1'b1
	} slot_state_e;

endpackage

// ==== tb_parallel_block_looper.sv ====
// Self-checking testbench for the block looper, with random jobs, random workers and a raster reference
`timescale 1ns/1ps

module tb_parallel_block_looper;

	localparam int WORK_BW     = tau_pkg::WORK_BW_DEF;
	localparam int VDIM        = tau_pkg::VDIM_DEF;
	localparam int N_TAU       = tau_pkg::N_TAU_DEF;
	localparam int MAX_PENDING = tau_pkg::MAX_PENDING_DEF;

	// One block offset, coordinate d in word d
	typedef logic [VDIM-1:0][WORK_BW-1:0] ofs_t;

	logic               i_clk;
	logic               i_rst_n;
	logic               i_src_rdy;
	logic               o_src_ack;
	logic [WORK_BW-1:0] i_bgrid_step [VDIM];
	logic [WORK_BW-1:0] i_bgrid_end  [VDIM];
	logic [N_TAU-1:0]   o_bofs_rdys;
	logic [N_TAU-1:0]   i_bofs_acks;
	logic [WORK_BW-1:0] o_bofss [N_TAU][VDIM];
	logic [N_TAU-1:0]   i_blkdone_dvals;

	// ========================================
	// Reference and worker model state
	// ========================================
	// Offsets of the running job not yet seen at any worker
	ofs_t   exp_q [$];
	// Per lane, transfers minus done pulses
	int     pend_cnt [N_TAU];
	// Per lane, cycles left before each outstanding block reports done
	int     done_dly [N_TAU][$];
	int     n_err, n_xfer, n_src_ack, n_jobs, full_seen;
	int     base_ack, base_xfer, job_len, err_mark;
	// Worker behavior knobs, lane hold_lane never acks
	int     ack_pct   = 70;
	int     done_min  = 0;
	int     done_max  = 8;
	int     hold_lane = -1;
	// Cycle budget, fixed base plus a share per expected block
	longint budget = 2000;
	longint cyc;

	parallel_block_looper #(
		.WORK_BW     (WORK_BW),
		.VDIM        (VDIM),
		.N_TAU       (N_TAU),
		.MAX_PENDING (MAX_PENDING)
	) UUT (
		.i_clk           (i_clk),
		.i_rst_n         (i_rst_n),
		.i_src_rdy       (i_src_rdy),
		.o_src_ack       (o_src_ack),
		.i_bgrid_step    (i_bgrid_step),
		.i_bgrid_end     (i_bgrid_end),
		.o_bofs_rdys     (o_bofs_rdys),
		.i_bofs_acks     (i_bofs_acks),
		.o_bofss         (o_bofss),
		.i_blkdone_dvals (i_blkdone_dvals)
	);

	// 8 ns clock
	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	// ========================================
	// Compare tasks and helpers
	// ========================================
	task automatic check_offset(input string name, input ofs_t got, input ofs_t exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%h exp 0x%h", name, got, exp);
			n_err++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%h exp 0x%h", name, got, exp);
			n_err++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%h exp 0x%h", name, got, exp);
			n_err++;
		end
	endtask

	function automatic ofs_t lane_offset(input int l);
		ofs_t o;
		for (int d = 0; d < VDIM; d++) begin
			o[d] = o_bofss[l][d];
		end
		return o;
	endfunction

	// Same value in every coordinate
	function automatic ofs_t uniform_offset(input int v);
		ofs_t o;
		for (int d = 0; d < VDIM; d++) begin
			o[d] = WORK_BW'(v);
		end
		return o;
	endfunction

	// Raster list from zero, last dimension fastest
	// empty as soon as one end is zero
	task automatic build_raster(input ofs_t stp, input ofs_t lim);
		ofs_t cur;
		int   nxt;
		bit   carry;
		exp_q.delete();
		cur   = '0;
		carry = 1'b0;
		for (int d = 0; d < VDIM; d++) begin
			if (lim[d] == 0) carry = 1'b1;
		end
		while (!carry) begin
			exp_q.push_back(cur);
			carry = 1'b1;
			for (int d = VDIM - 1; d >= 0 && carry; d--) begin
				nxt = int'(cur[d]) + int'(stp[d]);
				if (nxt < int'(lim[d])) begin
					cur[d] = WORK_BW'(nxt);
					carry  = 1'b0;
				end else begin
					cur[d] = '0;
				end
			end
		end
	endtask

	task automatic start_job(input ofs_t stp, input ofs_t lim);
		build_raster(stp, lim);
		job_len   = exp_q.size();
		budget    = budget + 40 * job_len;
		base_ack  = n_src_ack;
		base_xfer = n_xfer;
		n_jobs++;
		@(negedge i_clk);
		for (int d = 0; d < VDIM; d++) begin
			i_bgrid_step[d] = stp[d];
			i_bgrid_end[d]  = lim[d];
		end
		i_src_rdy = 1'b1;
	endtask

	// Source ack ends the job, a second one would show up in the idle cycles after
	task automatic wait_job();
		while (n_src_ack == base_ack) @(negedge i_clk);
		i_src_rdy = 1'b0;
		check_count("offset transfers in job", n_xfer - base_xfer, job_len);
		repeat (2) @(negedge i_clk);
		check_count("source acks in job", n_src_ack - base_ack, 1);
	endtask

	task automatic report_test(input int num, input string name);
		$display("test %0d (%s) %s, %0d errors", num, name,
			(n_err == err_mark) ? "passed" : "failed", n_err - err_mark);
	endtask

	// ========================================
	// Worker model, drives on the falling edge
	// ========================================
	always @(negedge i_clk) begin
		for (int l = 0; l < N_TAU; l++) begin
			i_bofs_acks[l]     = 1'b0;
			i_blkdone_dvals[l] = 1'b0;
			if (i_rst_n && o_bofs_rdys[l] && l != hold_lane) begin
				i_bofs_acks[l] = ($urandom_range(99, 0) < ack_pct);
			end
			// Blocks finish in the order they were received
			if (i_rst_n && done_dly[l].size() > 0) begin
				if (done_dly[l][0] == 0) begin
					i_blkdone_dvals[l] = 1'b1;
					void'(done_dly[l].pop_front());
				end else begin
					done_dly[l][0]--;
				end
			end
		end
	end

	// ========================================
	// Monitor, samples on the rising edge
	// ========================================
	always @(posedge i_clk) begin
		ofs_t got;
		int   hit;
		if (i_rst_n) begin
			if (o_src_ack) begin
				n_src_ack++;
				check_flag("i_src_rdy at source ack", i_src_rdy, 1'b1);
				check_count("offsets left at source ack", exp_q.size(), 0);
				for (int l = 0; l < N_TAU; l++) begin
					check_count($sformatf("pending lane %0d at source ack", l), pend_cnt[l], 0);
				end
			end
			for (int l = 0; l < N_TAU; l++) begin
				// Lane at its limit must not offer
				if (pend_cnt[l] == MAX_PENDING) begin
					full_seen++;
					check_flag($sformatf("o_bofs_rdys[%0d]", l), o_bofs_rdys[l], 1'b0);
				end
				if (o_bofs_rdys[l] && i_bofs_acks[l]) begin
					got = lane_offset(l);
					hit = -1;
					// Held offsets are always the oldest N_TAU not yet transferred
					for (int k = 0; k < N_TAU && k < exp_q.size(); k++) begin
						if (hit < 0 && exp_q[k] == got) hit = k;
					end
					if (hit >= 0) begin
						exp_q.delete(hit);
					end else if (exp_q.size() == 0) begin
						$display("Lane %0d transferred an offset that no job asked for", l);
						n_err++;
					end else begin
						check_offset($sformatf("o_bofss[%0d]", l), got, exp_q.pop_front());
					end
					n_xfer++;
					pend_cnt[l]++;
					done_dly[l].push_back($urandom_range(done_max, done_min));
				end
				if (i_blkdone_dvals[l]) pend_cnt[l]--;
			end
		end
	end

	// ========================================
	// Watchdog
	// ========================================
	initial begin
		cyc = 0;
		while (cyc <= budget) begin
			@(posedge i_clk);
			cyc++;
		end
		$display("Timeout after %0d cycles, a job never completed", cyc);
		$display("Test FAILED");
		$finish;
	end

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		ofs_t stp;
		ofs_t lim;
		void'($urandom(32'h49a70050));
		i_rst_n         = 1'b0;
		i_src_rdy       = 1'b0;
		i_bofs_acks     = '0;
		i_blkdone_dvals = '0;
		for (int d = 0; d < VDIM; d++) begin
			i_bgrid_step[d] = '0;
			i_bgrid_end[d]  = '0;
		end
		repeat (10) @(negedge i_clk);
		i_rst_n = 1'b1;

		// Idle outputs straight after reset
		err_mark = n_err;
		@(negedge i_clk);
		check_flag("o_src_ack", o_src_ack, 1'b0);
		for (int l = 0; l < N_TAU; l++) begin
			check_flag($sformatf("o_bofs_rdys[%0d]", l), o_bofs_rdys[l], 1'b0);
			check_offset($sformatf("o_bofss[%0d]", l), lane_offset(l), '0);
		end
		report_test(1, "idle after reset");

		// Random grids against the raster list
		err_mark = n_err;
		repeat (20) begin
			for (int d = 0; d < VDIM; d++) begin
				stp[d] = WORK_BW'($urandom_range(9, 1));
				lim[d] = WORK_BW'($urandom_range(40, 1));
			end
			start_job(stp, lim);
			wait_job();
		end
		report_test(2, "random jobs");

		// Slow done pulses fill every lane up to its limit
		err_mark  = n_err;
		full_seen = 0;
		ack_pct   = 100;
		done_min  = 40;
		done_max  = 80;
		start_job(uniform_offset(1), uniform_offset(8));
		wait_job();
		check_flag("lane reached its pending limit", full_seen > 0, 1'b1);
		ack_pct  = 70;
		done_min = 0;
		done_max = 8;
		report_test(3, "pending limit");

		err_mark = n_err;
		check_count("source acks over all jobs", n_src_ack, n_jobs);
		report_test(4, "one source ack per job");

		// Zero end in dimension 0, nothing to issue
		err_mark = n_err;
		lim      = uniform_offset(20);
		lim[0]   = '0;
		start_job(uniform_offset(2), lim);
		wait_job();
		report_test(5, "empty grid");

		// Lane 0 stalls, the other lanes drain the rest of the grid
		err_mark  = n_err;
		hold_lane = 0;
		start_job(uniform_offset(2), uniform_offset(16));
		while (exp_q.size() > 1) @(negedge i_clk);
		repeat (50) @(negedge i_clk);
		check_count("source acks while lane 0 held", n_src_ack, base_ack);
		check_flag("o_bofs_rdys[0]", o_bofs_rdys[0], 1'b1);
		hold_lane = -1;
		wait_job();
		report_test(6, "held lane");

		$display("%0d jobs, %0d offsets, %0d errors", n_jobs, n_xfer, n_err);
		if (n_err == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== worker_issue_slot.sv ====
// One worker lane: holds one offset for its worker and counts blocks not yet reported done
`timescale 1ns/1ps

module worker_issue_slot #(
	parameter int WORK_BW     = tau_pkg::WORK_BW_DEF,
	parameter int VDIM        = tau_pkg::VDIM_DEF,
	parameter int MAX_PENDING = tau_pkg::MAX_PENDING_DEF
) (
	input  logic               i_clk,
	input  logic               i_rst_n,
	// Take side, from the round-robin selector
	input  logic               i_take,
	output logic               o_free,
	input  logic [WORK_BW-1:0] i_ofs  [VDIM],
	// Worker side
	output logic               o_bofs_rdy,
	input  logic               i_bofs_ack,
	output logic [WORK_BW-1:0] o_bofs [VDIM],
	input  logic               i_blkdone,
	// No offset held and nothing outstanding
	output logic               o_idle
);

	// ========================================
	// Parameter
	// ========================================
	localparam int CNT_BW = $clog2(MAX_PENDING + 1);

	// ========================================
	// Internal
	// ========================================
	tau_pkg::slot_state_e state_r;
	logic [CNT_BW-1:0] pend_r;
	logic pend_full;
	logic pend_zero;
	logic bofs_xfer;

	// ========================================
	// Combinational
	// ========================================
	assign pend_full = (pend_r == CNT_BW'(MAX_PENDING));
	assign pend_zero = (pend_r == '0);

	// Only an empty register accepts a new offset
	assign o_free = (state_r == tau_pkg::SLOT_EMPTY);

	// Offer gated by the pending count
	// while full the offset stays held but is hidden from the worker
	assign o_bofs_rdy = (state_r == tau_pkg::SLOT_HELD) && !pend_full;
	assign bofs_xfer  = o_bofs_rdy && i_bofs_ack;

	assign o_idle = pend_zero && o_free;

	// ========================================
	// Forward register
	// ========================================
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state_r <= tau_pkg::SLOT_EMPTY;
		end else begin
			case (state_r)
				tau_pkg::SLOT_EMPTY: begin
					if (i_take) state_r <= tau_pkg::SLOT_HELD;
				end
				tau_pkg::SLOT_HELD: begin
					if (bofs_xfer) state_r <= tau_pkg::SLOT_EMPTY;
				end
				default: state_r <= tau_pkg::SLOT_EMPTY;
			endcase
		end
	end

	// Offset register, cleared at reset so the lane output starts at zero
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int d = 0; d < VDIM; d++) begin
				o_bofs[d] <= '0;
			end
		end else if (i_take && o_free) begin
			o_bofs <= i_ofs;
		end
	end

	// ========================================
	// Pending counter
	// ========================================
	// Up on each worker transfer, down on each done pulse
	// both in one cycle leave it unchanged
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			pend_r <= '0;
		end else begin
			case ({bofs_xfer, i_blkdone})
				2'b10: begin
					// Saturate at the limit
					if (!pend_full) pend_r <= pend_r + 1'b1;
				end
				2'b01: begin
					// A stray done on an empty count is ignored
					if (!pend_zero) pend_r <= pend_r - 1'b1;
				end
				default: begin
					pend_r <= pend_r;
				end
			endcase
		end
	end

endmodule
